/* buffer_state_model.sv */
// Buffer-state model choosing the job length of each machine
// Input registers for the read requests, not-empty and dequeue
// Read-request arbiter automaton G7 and dequeue-pending automaton G12
// One mode bit per machine, 1 selects the short job length

`timescale 1ns/1ps
`default_nettype none

module buffer_state_model (
  input  wire       clk,
  input  wire       i_rst_n,
  input  wire       i_btor_req0,
  input  wire       i_btor_req1,
  input  wire       i_nempty,
  input  wire       i_deq,
  output logic [1:0] o_short_mode
);

  // Registered copies of the buffer-control inputs
  logic r_req0;
  logic r_req1;
  logic r_nempty;
  logic r_deq;

  // G7 state, bit 1 is kept inverted
  logic g7_s0;
  logic g7_ns1;

  // G12 state, set while a dequeue is pending
  logic g12;

  // ==========================================================================
  // Input registers
  // ==========================================================================

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      r_req0   <= 1'b0;
      r_req1   <= 1'b0;
      r_nempty <= 1'b0;
      r_deq    <= 1'b0;
    end else begin
      r_req0   <= i_btor_req0;
      r_req1   <= i_btor_req1;
      r_nempty <= i_nempty;
      r_deq    <= i_deq;
    end
  end

  // ==========================================================================
  // Automata, stepped from the registered inputs
  // ==========================================================================

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      g7_s0  <= 1'b0;
      g7_ns1 <= 1'b0;
      g12    <= 1'b0;
    end else begin
      // G7, first matching rule wins, otherwise hold
      if (g7_ns1 && !r_req0 && r_req1) begin
        g7_ns1 <= 1'b0;
        g7_s0  <= 1'b0;
      end else if (!g7_ns1 && r_req0 && !r_req1) begin
        g7_ns1 <= 1'b1;
        g7_s0  <= 1'b0;
      end else if (g7_ns1 && !r_req0 && !r_req1) begin
        g7_ns1 <= 1'b1;
        g7_s0  <= 1'b1;
      end else if (!g7_ns1 && !r_req0 && !r_req1) begin
        g7_ns1 <= 1'b0;
        g7_s0  <= 1'b1;
      end

      // G12 sets on data waiting without a dequeue, clears on dequeue
      if (!g12 && r_nempty && !r_deq) begin
        g12 <= 1'b1;
      end else if (g12 && r_deq) begin
        g12 <= 1'b0;
      end
    end
  end

  // Machine 0 from G7 bit 0, machine 1 from inverted G7 bit 1 or G12
  assign o_short_mode = {g7_ns1 | g12, g7_s0};

endmodule

`default_nettype wire

/* machine_slot.sv */
// One machine slot of the dispatch controller
// Occupant task code and tick counter
// Job length picked per tick from the short-mode bit

`timescale 1ns/1ps
`default_nettype none

module machine_slot #(
  parameter int SHORT_TICKS = sched_pkg::DEF_SHORT_TICKS,
  parameter int LONG_TICKS  = sched_pkg::DEF_LONG_TICKS
) (
  input  wire     clk,
  input  wire     i_rst_n,
  input  wire     i_short_mode,
  slot_if.slot    slot
);
  import sched_pkg::*;

  // Last counter value of a job, one less than its length
  localparam logic [CNT_W-1:0] SHORT_LAST = CNT_W'(SHORT_TICKS - 1);
  localparam logic [CNT_W-1:0] LONG_LAST  = CNT_W'(LONG_TICKS - 1);

  task_e             occ_q;
  logic [CNT_W-1:0]  cnt_q;
  logic [CNT_W-1:0]  last_cnt;
  logic              busy;

  assign busy = (occ_q != TASK_IDLE);

  // Length follows the mode bit of the cycle in which the tick arrives
  assign last_cnt = i_short_mode ? SHORT_LAST : LONG_LAST;

  // ==========================================================================
  // Occupancy and tick counting
  // ==========================================================================

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      occ_q <= TASK_IDLE;
      cnt_q <= '0;
    end else if (slot.load) begin
      // New job starts at count 0
      occ_q <= slot.load_task;
      cnt_q <= '0;
    end else if (slot.advance && busy) begin
      if (cnt_q < last_cnt) begin
        cnt_q <= cnt_q + 1'b1;
      end else begin
        // Final tick of the job, machine frees itself
        occ_q <= TASK_IDLE;
        cnt_q <= '0;
      end
    end
  end

  // Status back to the dispatcher
  assign slot.busy     = busy;
  assign slot.cur_task = occ_q;

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Build the dispatch controller testbench with Verilator, run it, check the log

set -u
cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module tb_sched \
  -Mdir "$BUILD_DIR" -o tb_sched
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/tb_sched" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "RESULT: FAIL" "$LOG"; then
  echo "Testbench reported a failure, see $LOG"
  exit 1
fi

echo "Simulation finished without failures"
exit 0

/* sched_assert.sv */
// Concurrent assertions on the dispatcher
// Exclusive slot commands, sticky error, nothing accepted while unarmed

`timescale 1ns/1ps
`default_nettype none

module sched_assert (
  input wire clk,
  input wire i_rst_n,
  input wire i_load0,
  input wire i_advance0,
  input wire i_load1,
  input wire i_advance1,
  input wire i_acc_a,
  input wire i_acc_b,
  input wire i_acc_tick,
  input wire i_error
);

  // Load and advance never together on one slot
  a_slot0_cmd: assert property (@(posedge clk) disable iff (!i_rst_n)
    !(i_load0 && i_advance0))
    else $error("Slot 0 got load and advance in the same cycle");

  a_slot1_cmd: assert property (@(posedge clk) disable iff (!i_rst_n)
    !(i_load1 && i_advance1))
    else $error("Slot 1 got load and advance in the same cycle");

  // Error flag holds until the next reset
  a_error_sticky: assert property (@(posedge clk) disable iff (!i_rst_n)
    i_error |=> i_error)
    else $error("Error flag dropped without a reset");

  // First cycle after reset release, controller still unarmed
  a_unarmed_idle: assert property (@(posedge clk)
    !$past(i_rst_n) |-> !(i_acc_a || i_acc_b || i_acc_tick))
    else $error("Arrival accepted in the first cycle after reset");

endmodule

`default_nettype wire

/* sched_pkg.sv */
// Shared definitions for the two-machine task dispatch controller
// Task codes held by a machine slot
// Machine count, default job lengths and tick counter width

`default_nettype none

package sched_pkg;

  // ==========================================================================
  // Machine occupant codes
  // ==========================================================================

  // Idle means the machine can take a new task
  typedef enum logic [1:0] {
    TASK_IDLE = 2'd0,
    TASK_A    = 2'd1,
    TASK_B    = 2'd2
  } task_e;

  // ==========================================================================
  // Sizing and timing defaults
  // ==========================================================================

  // Machines served by the dispatcher
  localparam int NUM_MACHINES = 2;

  // Job length in ticks when the machine's mode bit is 1
  localparam int DEF_SHORT_TICKS = 2;

  // Job length in ticks when the machine's mode bit is 0
  localparam int DEF_LONG_TICKS = 3;

  // Tick counter width, covers lengths up to 8
  localparam int CNT_W = 3;

endpackage

`default_nettype wire

/* sched_stimulus.txt */
// test a b tick sel0 sel1 req0 req1 nempty deq  acc_a acc_b acc_tick error busy
// busy is machine 1 then machine 0; every test starts in the cycle after a reset
// 1: arming, then a tick on the loaded machine
1  1 0 1 1 0 0 0 0 0  0 0 0 0 00
1  1 0 1 1 0 0 0 0 0  1 0 0 0 00
1  0 0 1 0 0 0 0 0 0  0 0 1 0 01
// 2: priority A over B over tick, short job on 0, long job on 1
2  0 0 0 0 0 0 0 0 0  0 0 0 0 00
2  1 1 1 1 0 0 0 0 0  1 0 0 0 00
2  0 1 1 0 1 0 0 0 0  0 1 0 0 01
2  0 0 1 0 0 0 0 0 0  0 0 1 0 11
2  0 0 1 0 0 0 0 0 0  0 0 1 0 11
2  0 0 1 0 0 0 0 0 0  0 0 1 0 10
2  0 0 0 0 0 0 0 0 0  0 0 0 0 00
// 3: req0 held high clears mode bit 0, three-tick job on machine 0
3  0 0 0 0 0 1 0 0 0  0 0 0 0 00
3  1 0 0 1 0 1 0 0 0  1 0 0 0 00
3  0 0 1 0 0 1 0 0 0  0 0 1 0 01
3  0 0 1 0 0 1 0 0 0  0 0 1 0 01
3  0 0 1 0 0 1 0 0 0  0 0 1 0 01
3  0 0 0 0 0 1 0 0 0  0 0 0 0 00
// 4: requests low and nempty high, two-tick jobs on both machines
4  0 0 0 0 0 0 0 1 0  0 0 0 0 00
4  1 0 0 1 0 0 0 1 0  1 0 0 0 00
4  0 1 0 0 1 0 0 1 0  0 1 0 0 01
4  0 0 1 0 0 0 0 1 0  0 0 1 0 11
4  0 0 1 0 0 0 0 1 0  0 0 1 0 11
4  0 0 0 0 0 0 0 1 0  0 0 0 0 00
// 5: busy machine selected, starts refused, ticks still run
5  0 0 0 0 0 0 0 0 0  0 0 0 0 00
5  1 0 0 1 0 0 0 0 0  1 0 0 0 00
5  0 0 0 1 0 0 0 0 0  0 0 0 0 01
5  1 0 1 0 1 0 0 0 0  0 0 1 1 01
5  0 1 0 0 0 0 0 0 0  0 0 0 1 01
5  0 0 1 0 0 0 0 0 0  0 0 1 1 01
5  0 0 0 0 0 0 0 0 0  0 0 0 1 00
// 6: start with no select
6  0 0 0 0 0 0 0 0 0  0 0 0 0 00
6  1 0 0 0 0 0 0 0 0  1 0 0 0 00
6  0 0 1 0 0 0 0 0 0  0 0 1 1 00

/* sched_top.sv */
// Top level of the two-machine task dispatch controller
// Dispatcher, buffer-state model and two machine slots
// Job lengths set here and passed to both slots

`timescale 1ns/1ps
`default_nettype none

module sched_top #(
  parameter int SHORT_TICKS = sched_pkg::DEF_SHORT_TICKS,
  parameter int LONG_TICKS  = sched_pkg::DEF_LONG_TICKS
) (
  input  wire                                clk,
  input  wire                                i_rst_n,
  input  wire                                i_start_a,
  input  wire                                i_start_b,
  input  wire                                i_tick,
  input  wire                                i_sched0,
  input  wire                                i_sched1,
  input  wire                                i_btor_req0,
  input  wire                                i_btor_req1,
  input  wire                                i_nempty,
  input  wire                                i_deq,
  output logic                               o_acc_start_a,
  output logic                               o_acc_start_b,
  output logic                               o_acc_tick,
  output logic                               o_error,
  output logic [sched_pkg::NUM_MACHINES-1:0] o_machine_busy,
  output sched_pkg::task_e                   o_machine0_task,
  output sched_pkg::task_e                   o_machine1_task
);
  import sched_pkg::*;

  // Per-machine short-mode bits from the buffer model
  logic [NUM_MACHINES-1:0] short_mode;

  // Dispatcher to slot links
  slot_if slot0 ();
  slot_if slot1 ();

  task_dispatch u_dispatch (
    .clk           (clk),
    .i_rst_n       (i_rst_n),
    .i_start_a     (i_start_a),
    .i_start_b     (i_start_b),
    .i_tick        (i_tick),
    .i_sched0      (i_sched0),
    .i_sched1      (i_sched1),
    .slot0         (slot0.dispatch),
    .slot1         (slot1.dispatch),
    .o_acc_start_a (o_acc_start_a),
    .o_acc_start_b (o_acc_start_b),
    .o_acc_tick    (o_acc_tick),
    .o_error       (o_error)
  );

  buffer_state_model u_buffer_model (
    .clk          (clk),
    .i_rst_n      (i_rst_n),
    .i_btor_req0  (i_btor_req0),
    .i_btor_req1  (i_btor_req1),
    .i_nempty     (i_nempty),
    .i_deq        (i_deq),
    .o_short_mode (short_mode)
  );

  // Machine 0
  machine_slot #(
    .SHORT_TICKS (SHORT_TICKS),
    .LONG_TICKS  (LONG_TICKS)
  ) u_machine0 (
    .clk          (clk),
    .i_rst_n      (i_rst_n),
    .i_short_mode (short_mode[0]),
    .slot         (slot0.slot)
  );

  // Machine 1
  machine_slot #(
    .SHORT_TICKS (SHORT_TICKS),
    .LONG_TICKS  (LONG_TICKS)
  ) u_machine1 (
    .clk          (clk),
    .i_rst_n      (i_rst_n),
    .i_short_mode (short_mode[1]),
    .slot         (slot1.slot)
  );

  // Machine status to the outside
  assign o_machine_busy  = {slot1.busy, slot0.busy};
  assign o_machine0_task = slot0.cur_task;
  assign o_machine1_task = slot1.cur_task;

endmodule

`default_nettype wire

/* sim.f */
sched_pkg.sv
slot_if.sv
buffer_state_model.sv
machine_slot.sv
task_dispatch.sv
sched_top.sv
tb_clock_gen.sv
sched_assert.sv
tb_sched.sv

/* slot_if.sv */
// Link between the dispatcher and one machine slot
// Load and advance commands one way, occupancy status the other way

`timescale 1ns/1ps
`default_nettype none

interface slot_if;
  import sched_pkg::*;

  // Commands, each a single-cycle pulse taken at the next rising edge
  logic  load;
  task_e load_task;
  logic  advance;

  // Slot status
  logic  busy;
  // Current occupant of the machine
  task_e cur_task;

  // Dispatcher side
  modport dispatch (
    output load, load_task, advance,
    input  busy, cur_task
  );

  // Machine side
  modport slot (
    input  load, load_task, advance,
    output busy, cur_task
  );

endinterface

`default_nettype wire

/* task_dispatch.sv */
// Dispatcher of the two-machine controller
// Armed flag, nothing is taken in the first cycle after reset
// Arrival priority A, then B, then tick
// Slot load and advance commands, sticky error flag

`timescale 1ns/1ps
`default_nettype none

module task_dispatch (
  input  wire       clk,
  input  wire       i_rst_n,
  input  wire       i_start_a,
  input  wire       i_start_b,
  input  wire       i_tick,
  input  wire       i_sched0,
  input  wire       i_sched1,
  slot_if.dispatch  slot0,
  slot_if.dispatch  slot1,
  output logic      o_acc_start_a,
  output logic      o_acc_start_b,
  output logic      o_acc_tick,
  output logic      o_error
);
  import sched_pkg::*;

  logic armed_q;
  logic err_q;

  logic acc_a;
  logic acc_b;
  logic acc_tick;
  logic acc_start;
  logic err_set;

  // ==========================================================================
  // Arrival acceptance
  // ==========================================================================

  // Starts are refused once the error flag is up
  assign acc_a     = armed_q && !err_q && i_start_a;
  assign acc_b     = armed_q && !err_q && !acc_a && i_start_b;
  // Ticks keep running even after an error
  assign acc_tick  = armed_q && !acc_a && !acc_b && i_tick;
  assign acc_start = acc_a || acc_b;

  assign o_acc_start_a = acc_a;
  assign o_acc_start_b = acc_b;
  assign o_acc_tick    = acc_tick;

  // ==========================================================================
  // Slot commands
  // ==========================================================================

  // Machine 0 wins when both selects are high
  assign slot0.load = acc_start && i_sched0;
  assign slot1.load = acc_start && !i_sched0 && i_sched1;

  // Same task code offered to both, only the loaded slot takes it
  assign slot0.load_task = acc_a ? TASK_A : TASK_B;
  assign slot1.load_task = acc_a ? TASK_A : TASK_B;

  // A tick is never accepted together with a start
  assign slot0.advance = acc_tick;
  assign slot1.advance = acc_tick;

  // ==========================================================================
  // Error detection
  // ==========================================================================

  // Busy machine selected, or a start with nowhere to go
  assign err_set = armed_q &&
                   ((i_sched0 && slot0.busy) ||
                    (i_sched1 && slot1.busy) ||
                    (acc_start && !i_sched0 && !i_sched1));

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      armed_q <= 1'b0;
      err_q   <= 1'b0;
    end else begin
      armed_q <= 1'b1;
      // Sticky until the next reset
      if (err_set) begin
        err_q <= 1'b1;
      end
    end
  end

  assign o_error = err_q;

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
// Clock and power-on reset for the testbench
// Free-running clock, reset released on a falling edge

`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD_NS  = 40,
  parameter int RST_CYCLES = 2
) (
  output logic clk,
  output logic o_rst_n
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // Low for RST_CYCLES rising edges, then released mid-cycle
  initial begin
    o_rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    o_rst_n = 1'b1;
  end

endmodule

`default_nettype wire

/* tb_sched.sv */
// Testbench for the two-machine task dispatch controller
// Per-cycle stimulus and expected outputs read from a text file
// Inputs change on the falling edge, outputs checked before the rising edge

`timescale 1ns/1ps
`default_nettype none

module tb_sched;
  import sched_pkg::*;

  localparam int MAX_LINES = 64;
  localparam int SEED      = 17827;

  logic       clk;
  logic       gen_rst_n;
  logic       tb_rst_n;
  // start_a, start_b, tick, sched0, sched1, req0, req1, nempty, deq
  logic [8:0] in_bits;
  // acc_start_a, acc_start_b, acc_tick
  logic [2:0] acc;
  logic       error;
  logic [1:0] busy;
  task_e      m0_task;
  task_e      m1_task;

  // Parsed file, expected is acc a, acc b, acc tick, error, busy
  int         line_test [MAX_LINES];
  logic [8:0] line_in   [MAX_LINES];
  logic [5:0] line_exp  [MAX_LINES];
  int         num_lines;

  // Task code last loaded on each machine by an accepted start
  task_e      loaded0;
  task_e      loaded1;

  int         cycle_cnt;
  int         cycle_limit;
  int         test_errs;
  int         total_errs;
  int         tests_passed;
  int         tests_failed;

  tb_clock_gen #(.PERIOD_NS(40), .RST_CYCLES(2)) u_clk_gen (
    .clk     (clk),
    .o_rst_n (gen_rst_n)
  );

  sched_top DUT (
    .clk             (clk),
    .i_rst_n         (gen_rst_n & tb_rst_n),
    .i_start_a       (in_bits[8]),
    .i_start_b       (in_bits[7]),
    .i_tick          (in_bits[6]),
    .i_sched0        (in_bits[5]),
    .i_sched1        (in_bits[4]),
    .i_btor_req0     (in_bits[3]),
    .i_btor_req1     (in_bits[2]),
    .i_nempty        (in_bits[1]),
    .i_deq           (in_bits[0]),
    .o_acc_start_a   (acc[2]),
    .o_acc_start_b   (acc[1]),
    .o_acc_tick      (acc[0]),
    .o_error         (error),
    .o_machine_busy  (busy),
    .o_machine0_task (m0_task),
    .o_machine1_task (m1_task)
  );

  bind task_dispatch sched_assert u_sched_assert (
    .clk        (clk),
    .i_rst_n    (i_rst_n),
    .i_load0    (slot0.load),
    .i_advance0 (slot0.advance),
    .i_load1    (slot1.load),
    .i_advance1 (slot1.advance),
    .i_acc_a    (o_acc_start_a),
    .i_acc_b    (o_acc_start_b),
    .i_acc_tick (o_acc_tick),
    .i_error    (o_error)
  );

  // ==========================================================================
  // Run limit
  // ==========================================================================

  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
      $display("Timeout after %0d cycles, the test sequence did not complete", cycle_cnt);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  // ==========================================================================
  // Helpers
  // ==========================================================================

  task automatic load_stimulus();
    int    fd;
    int    rc;
    int    k;
    int    fld [15];
    string text;
    num_lines = 0;
    fd = $fopen("sched_stimulus.txt", "r");
    if (fd == 0) begin
      $display("Stimulus file sched_stimulus.txt could not be opened");
    end else begin
      while (!$feof(fd) && num_lines < MAX_LINES) begin
        text = "";
        rc = $fgets(text, fd);
        rc = $sscanf(text, "%d %b %b %b %b %b %b %b %b %b %b %b %b %b %b",
                     fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6], fld[7],
                     fld[8], fld[9], fld[10], fld[11], fld[12], fld[13], fld[14]);
        // Comment and blank lines give fewer fields
        if (rc == 15) begin
          line_test[num_lines] = fld[0];
          for (k = 1; k <= 9; k++) begin
            line_in[num_lines][9 - k] = fld[k][0];
          end
          line_exp[num_lines] = {fld[10][0], fld[11][0], fld[12][0], fld[13][0],
                                 fld[14][1:0]};
          num_lines++;
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic report_mismatch(input int idx, input string what,
                                 input logic [1:0] got, input logic [1:0] exp);
    $display("** Error @ %0d ns: line %0d, %s is %b, expected %b",
             $time, idx + 1, what, got, exp);
    test_errs++;
  endtask

  // Occupant expected on a machine, idle unless the file expects it busy
  function automatic task_e expected_task(input logic exp_busy, input task_e loaded);
    if (exp_busy) begin
      return loaded;
    end else begin
      return TASK_IDLE;
    end
  endfunction

  // A start accepted per the file loads machine 0 first, else machine 1
  task automatic track_load(input int idx);
    task_e code;
    if (line_exp[idx][5] || line_exp[idx][4]) begin
      code = line_exp[idx][5] ? TASK_A : TASK_B;
      if (line_in[idx][5]) begin
        loaded0 = code;
      end else if (line_in[idx][4]) begin
        loaded1 = code;
      end
    end
  endtask

  task automatic check_line(input int idx);
    task_e exp0;
    task_e exp1;
    exp0 = expected_task(line_exp[idx][0], loaded0);
    exp1 = expected_task(line_exp[idx][1], loaded1);
    if (acc[2] !== line_exp[idx][5])
      report_mismatch(idx, "o_acc_start_a", {1'b0, acc[2]}, {1'b0, line_exp[idx][5]});
    if (acc[1] !== line_exp[idx][4])
      report_mismatch(idx, "o_acc_start_b", {1'b0, acc[1]}, {1'b0, line_exp[idx][4]});
    if (acc[0] !== line_exp[idx][3])
      report_mismatch(idx, "o_acc_tick", {1'b0, acc[0]}, {1'b0, line_exp[idx][3]});
    if (error !== line_exp[idx][2])
      report_mismatch(idx, "o_error", {1'b0, error}, {1'b0, line_exp[idx][2]});
    if (busy !== line_exp[idx][1:0])
      report_mismatch(idx, "o_machine_busy", busy, line_exp[idx][1:0]);
    if (m0_task !== exp0)
      report_mismatch(idx, "o_machine0_task", m0_task, exp0);
    if (m1_task !== exp1)
      report_mismatch(idx, "o_machine1_task", m1_task, exp1);
  endtask

  task automatic finish_test(input int id);
    if (test_errs == 0) begin
      tests_passed++;
      $display("Test %0d finished, no mismatches", id);
    end else begin
      tests_failed++;
      $display("Test %0d finished with %0d mismatches", id, test_errs);
    end
    total_errs += test_errs;
    test_errs = 0;
  endtask

  // Random-length reset between tests, entered and left on a falling edge
  task automatic reset_gap();
    int gap;
    gap = 1 + int'($urandom % 2);
    tb_rst_n = 1'b0;
    in_bits  = '0;
    loaded0  = TASK_IDLE;
    loaded1  = TASK_IDLE;
    repeat (gap) @(negedge clk);
    tb_rst_n = 1'b1;
  endtask

  // ==========================================================================
  // Main sequence
  // ==========================================================================

  initial begin
    int i;
    in_bits      = '0;
    tb_rst_n     = 1'b1;
    loaded0      = TASK_IDLE;
    loaded1      = TASK_IDLE;
    cycle_cnt    = 0;
    cycle_limit  = 0;
    test_errs    = 0;
    total_errs   = 0;
    tests_passed = 0;
    tests_failed = 0;
    void'($urandom(SEED));
    load_stimulus();
    cycle_limit = num_lines + 20;
    wait (gen_rst_n === 1'b1);
    if (num_lines == 0) begin
      $display("No stimulus lines were read, nothing was tested");
      $display("RESULT: FAIL");
    end else begin
      for (i = 0; i < num_lines; i++) begin
        if (i > 0 && line_test[i] != line_test[i - 1]) begin
          finish_test(line_test[i - 1]);
          reset_gap();
        end
        in_bits = line_in[i];
        #10;
        check_line(i);
        track_load(i);
        @(negedge clk);
      end
      finish_test(line_test[num_lines - 1]);
      $display("Tests passed: %0d, tests failed: %0d, mismatches: %0d",
               tests_passed, tests_failed, total_errs);
      if (tests_failed == 0) begin
        $display("RESULT: PASS");
      end else begin
        $display("RESULT: FAIL");
      end
    end
    $finish;
  end

endmodule

`default_nettype wire
